// File: bench/fetch_vectors.txt
# T test expected_mispredictions
# R pc is_branch taken target  (hex, correct-path trace in order)
T 1 0
R 00000000 0 0 00000000
R 00000004 0 0 00000000
R 00000008 0 0 00000000
R 0000000c 0 0 00000000
R 00000010 0 0 00000000
R 00000014 0 0 00000000
R 00000018 0 0 00000000
R 0000001c 0 0 00000000
T 2 2
R 00000020 0 0 00000000
R 00000024 1 1 00000020
R 00000020 0 0 00000000
R 00000024 1 1 00000020
R 00000020 0 0 00000000
R 00000024 1 1 00000020
R 00000020 0 0 00000000
R 00000024 1 1 00000020
R 00000020 0 0 00000000
R 00000024 1 1 00000020
R 00000020 0 0 00000000
R 00000024 1 1 00000020
R 00000020 0 0 00000000
R 00000024 1 1 00000020
R 00000020 0 0 00000000
R 00000024 1 0 00000020
T 3 1
R 00000028 1 1 00000040
R 00000040 0 0 00000000
R 00000044 0 0 00000000
T 4 5
R 00000048 1 1 00000060
R 00000060 1 1 00000048
R 00000048 1 1 00000060
R 00000060 1 1 00000048
R 00000048 1 1 00000080
R 00000080 1 1 00000048
R 00000048 1 1 00000080
R 00000080 1 0 00000048
R 00000084 0 0 00000000
T 5 3
R 00000088 1 1 000000a0
R 000000a0 0 0 00000000
R 000000a4 1 1 00000048
R 00000048 1 0 00000080
R 0000004c 0 0 00000000
R 00000050 1 1 00000088
R 00000088 1 1 000000a0
R 000000a0 0 0 00000000

// File: vlog.f
+incdir+common
common/bp_pkg.sv
predictor/btb.sv
verilog/pc_sequencer.sv
verilog/imem_wb_master.sv
verilog/fetch_frontend.sv
bench/wb_imem_model.sv
bench/tb_fetch_frontend.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the fetch front end testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_fetch_frontend -f vlog.f -o sim_fetch \
	> build.log 2>&1 && ./obj_dir/sim_fetch > sim.log 2>&1 || echo "Build or run error"
cat sim.log 2>/dev/null
grep -q "^Test completed successfully$" sim.log && echo "PASS" && exit 0 || echo "FAIL"
exit 1

// File: bench/tb_fetch_frontend.sv
/*
 * Testbench for the fetch front end.
 * Plays the execute stage from the correct-path trace in the vector file,
 * checks fetch order and data, and counts mispredictions per test.
 */

`timescale 1ns/1ns
`default_nettype none

module tb_fetch_frontend;

	import bp_pkg::*;

	logic       clk;
	logic       rst_n;
	resolve_t   resolve_r;
	fetch_t     fetch_w;
	logic       wb_cyc;
	logic       wb_stb;
	logic       wb_we;
	addr_t      wb_adr;
	logic       wb_ack;
	instr_t     wb_dat;
	logic [1:0] wait_sel;

	addr_t rec_pc[$];
	logic  rec_br[$];
	logic  rec_tk[$];
	addr_t rec_tgt[$];
	int    rec_test[$];
	int    test_id[$];
	int    test_exp[$];
	int    test_mis[$];
	int    test_err[$];
	int    test_last[$];

	logic [31:0] lcg_state = 32'hd89512b7;
	int    rec_ptr;
	int    ignored;
	int    other_err;
	int    bus_err;
	int    tests_failed;
	int    cycles;
	int    limit;
	logic  all_done;
	logic  pending;
	addr_t corrected_pc;
	logic  cyc_seen;
	logic  ack_seen;
	addr_t held_adr;

	fetch_frontend u_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.resolve_i (resolve_r),
		.fetch_o   (fetch_w),
		.wb_cyc_o  (wb_cyc),
		.wb_stb_o  (wb_stb),
		.wb_we_o   (wb_we),
		.wb_adr_o  (wb_adr),
		.wb_ack_i  (wb_ack),
		.wb_dat_i  (wb_dat)
	);

	wb_imem_model u_imem (
		.clk      (clk),
		.rst_n    (rst_n),
		.wb_cyc_i (wb_cyc),
		.wb_stb_i (wb_stb),
		.wb_we_i  (wb_we),
		.wb_adr_i (wb_adr),
		.wb_ack_o (wb_ack),
		.wb_dat_o (wb_dat),
		.wait_i   (wait_sel)
	);

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic load_vectors();
		int    fd;
		int    code;
		string line;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] d;
		fd = $fopen("bench/fetch_vectors.txt", "r");
		if (fd == 0) begin
			$display("Could not open the vector file");
			other_err++;
			return;
		end
		while (!$feof(fd)) begin
			code = $fgets(line, fd);
			if (code == 0 || line.len() < 2) begin
				continue;
			end
			if (line.getc(0) == "T") begin
				code = $sscanf(line.substr(1, line.len() - 1), "%d %d", a, b);
				test_id.push_back(int'(a));
				test_exp.push_back(int'(b));
				test_mis.push_back(0);
				test_err.push_back(0);
				test_last.push_back(-1);
			end else if (line.getc(0) == "R" && test_id.size() > 0) begin
				code = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", a, b, c, d);
				rec_pc.push_back(a);
				rec_br.push_back(b[0]);
				rec_tk.push_back(c[0]);
				rec_tgt.push_back(d);
				rec_test.push_back(test_id.size() - 1);
				test_last[test_id.size() - 1] = rec_pc.size() - 1;
			end
		end
		$fclose(fd);
		if (rec_pc.size() == 0) begin
			$display("The vector file holds no trace records");
			other_err++;
		end
	endtask

	task automatic report_test(input int t);
		if (test_mis[t] != test_exp[t]) begin
			$display("Error: mispredict count of test %0d is 0x%h, expected 0x%h",
				test_id[t], test_mis[t], test_exp[t]);
			test_err[t]++;
		end
		if (test_err[t] != 0) begin
			tests_failed++;
		end
		$display("Result test %0d: %0d mispredictions, expected %0d, %0d errors, %s",
			test_id[t], test_mis[t], test_exp[t], test_err[t],
			(test_err[t] == 0) ? "ok" : "FAILED");
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Execute stage model resolving each correct-path word on the next edge.
	always @(posedge clk) begin
		fetch_t   f;
		resolve_t rv;
		logic     mis;
		int       t;
		f = fetch_w;
		rv = '0;
		if (rst_n && f.valid && !all_done) begin
			if (pending && f.pc != corrected_pc) begin
				ignored++;
			end else begin
				pending = 1'b0;
				t = rec_test[rec_ptr];
				if (f.pc != rec_pc[rec_ptr]) begin
					$display("Error: fetch_o.pc 0x%h, expected 0x%h", f.pc, rec_pc[rec_ptr]);
					test_err[t]++;
				end
				if (f.instr != ~rec_pc[rec_ptr]) begin
					$display("Error: fetch_o.instr 0x%h, expected 0x%h",
						f.instr, ~rec_pc[rec_ptr]);
					test_err[t]++;
				end
				rv.valid       = 1'b1;
				rv.is_branch   = rec_br[rec_ptr];
				rv.pc          = rec_pc[rec_ptr];
				rv.taken       = rec_tk[rec_ptr];
				rv.target      = rec_tgt[rec_ptr];
				rv.pred_taken  = f.pred_taken;
				rv.pred_target = f.pred_target;
				mis = (rec_tk[rec_ptr] != f.pred_taken) ||
					(rec_tk[rec_ptr] && rec_tgt[rec_ptr] != f.pred_target);
				if (mis) begin
					pending = 1'b1;
					corrected_pc = rec_tk[rec_ptr] ? rec_tgt[rec_ptr] : rec_pc[rec_ptr] + 32'd4;
					test_mis[t]++;
				end
				if (rec_ptr == test_last[t]) begin
					report_test(t);
				end
				rec_ptr++;
				if (rec_ptr == rec_pc.size()) begin
					all_done = 1'b1;
				end
			end
		end
		resolve_r <= rv;
		if (wb_cyc && wb_ack) begin
			lcg_state = lcg_step(lcg_state);
			wait_sel <= lcg_state[17:16];
		end
	end

	// Classic bus rules as seen from the memory side.
	always @(posedge clk) begin
		if (rst_n) begin
			if (wb_stb != wb_cyc) begin
				$display("Error: wb_stb_o 0x%h, expected 0x%h", wb_stb, wb_cyc);
				bus_err++;
			end
			if (wb_cyc && wb_we) begin
				$display("Error: wb_we_o 0x%h, expected 0x0", wb_we);
				bus_err++;
			end
			if (ack_seen && wb_cyc) begin
				$display("Error: wb_cyc_o 0x%h in the cycle after ack, expected 0x0", wb_cyc);
				bus_err++;
			end
			if (cyc_seen && !ack_seen && (!wb_cyc || wb_adr != held_adr)) begin
				$display("Error: wb_adr_o 0x%h with wb_cyc_o 0x%h, expected 0x%h with 0x1",
					wb_adr, wb_cyc, held_adr);
				bus_err++;
			end
		end
		cyc_seen = wb_cyc;
		ack_seen = wb_cyc && wb_ack;
		held_adr = wb_adr;
	end

	initial begin
		int total_err;
		rst_n = 1'b0;
		resolve_r = '0;
		wait_sel = lcg_state[17:16];
		rec_ptr = 0;
		ignored = 0;
		other_err = 0;
		bus_err = 0;
		tests_failed = 0;
		cycles = 0;
		all_done = 1'b0;
		pending = 1'b0;
		corrected_pc = '0;
		cyc_seen = 1'b0;
		ack_seen = 1'b0;
		held_adr = '0;
		load_vectors();
		limit = 20 * rec_pc.size() + 200;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		if (rec_pc.size() == 0) begin
			all_done = 1'b1;
		end
		while (!all_done && cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		if (!all_done) begin
			$display("Timeout after %0d cycles with %0d of %0d records resolved",
				cycles, rec_ptr, rec_pc.size());
			other_err++;
		end
		total_err = other_err + bus_err;
		foreach (test_err[i]) begin
			total_err += test_err[i];
		end
		$display("Summary: %0d tests, %0d failed, %0d records, %0d wrong-path words, %0d errors",
			test_id.size(), tests_failed, rec_pc.size(), ignored, total_err);
		if (total_err == 0 && tests_failed == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/wb_imem_model.sv
/*
 * Wishbone classic slave model of the instruction memory.
 * Returns the inverted address as data; the testbench picks the number
 * of wait states for each cycle through wait_i.
 */

`timescale 1ns/1ns
`default_nettype none

module wb_imem_model (
	input  wire                 clk,
	input  wire                 rst_n,
	input  wire                 wb_cyc_i,
	input  wire                 wb_stb_i,
	input  wire                 wb_we_i,
	input  wire bp_pkg::addr_t  wb_adr_i,
	output logic                wb_ack_o,
	output bp_pkg::instr_t      wb_dat_o,
	input  wire [1:0]           wait_i
);

	import bp_pkg::*;

	logic [1:0] cnt_q;
	logic       active;

	assign active = wb_cyc_i && wb_stb_i && !wb_we_i;

	// Ack once the wait count for this cycle has run out.
	assign wb_ack_o = active && (cnt_q == wait_i);
	assign wb_dat_o = ~wb_adr_i;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt_q <= 2'd0;
		end else if (active && !wb_ack_o) begin
			cnt_q <= cnt_q + 2'd1;
		end else begin
			cnt_q <= 2'd0;
		end
	end

endmodule

`default_nettype wire

// File: verilog/fetch_frontend.sv
/*
 * Instruction fetch front end top level.
 * Ties the PC sequencer, the BTB and the Wishbone fetch master together;
 * execute feeds resolve records back in.
 */

`timescale 1ns/1ns
`default_nettype none

module fetch_frontend (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire bp_pkg::resolve_t resolve_i,
	output bp_pkg::fetch_t        fetch_o,
	output logic                  wb_cyc_o,
	output logic                  wb_stb_o,
	output logic                  wb_we_o,
	output bp_pkg::addr_t         wb_adr_o,
	input  wire                   wb_ack_i,
	input  wire bp_pkg::instr_t   wb_dat_i
);

	import bp_pkg::*;

	logic  req_valid;
	logic  req_ready;
	addr_t req_pc;
	logic  req_pred_taken;
	addr_t req_pred_target;
	logic  btb_taken;
	addr_t btb_target;
	logic  flush;

	// BTB looks up the PC on offer in the same cycle.
	btb u_btb (
		.clk           (clk),
		.rst_n         (rst_n),
		.lookup_pc_i   (req_pc),
		.pred_taken_o  (btb_taken),
		.pred_target_o (btb_target),
		.update_i      (resolve_i)
	);

	pc_sequencer u_pc_sequencer (
		.clk               (clk),
		.rst_n             (rst_n),
		.resolve_i         (resolve_i),
		.pred_taken_i      (btb_taken),
		.pred_target_i     (btb_target),
		.req_ready_i       (req_ready),
		.req_valid_o       (req_valid),
		.req_pc_o          (req_pc),
		.req_pred_taken_o  (req_pred_taken),
		.req_pred_target_o (req_pred_target),
		.flush_o           (flush)
	);

	imem_wb_master u_imem_wb_master (
		.clk               (clk),
		.rst_n             (rst_n),
		.req_valid_i       (req_valid),
		.req_ready_o       (req_ready),
		.req_pc_i          (req_pc),
		.req_pred_taken_i  (req_pred_taken),
		.req_pred_target_i (req_pred_target),
		.flush_i           (flush),
		.wb_cyc_o          (wb_cyc_o),
		.wb_stb_o          (wb_stb_o),
		.wb_we_o           (wb_we_o),
		.wb_adr_o          (wb_adr_o),
		.wb_ack_i          (wb_ack_i),
		.wb_dat_i          (wb_dat_i),
		.fetch_o           (fetch_o)
	);

endmodule

`default_nettype wire

// File: verilog/imem_wb_master.sv
/*
 * Instruction fetch master on a Wishbone classic bus.
 * Takes one request at a time, runs a single read cycle for it and
 * presents the word on the fetch record unless a flush hit it.
 */

`timescale 1ns/1ns
`default_nettype none

module imem_wb_master (
	input  wire                 clk,
	input  wire                 rst_n,
	input  wire                 req_valid_i,
	output logic                req_ready_o,
	input  wire bp_pkg::addr_t  req_pc_i,
	input  wire                 req_pred_taken_i,
	input  wire bp_pkg::addr_t  req_pred_target_i,
	input  wire                 flush_i,
	output logic                wb_cyc_o,
	output logic                wb_stb_o,
	output logic                wb_we_o,
	output bp_pkg::addr_t       wb_adr_o,
	input  wire                 wb_ack_i,
	input  wire bp_pkg::instr_t wb_dat_i,
	output bp_pkg::fetch_t      fetch_o
);

	import bp_pkg::*;

	typedef enum logic {
		IDLE,
		BUSY
	} wb_state_t;

	wb_state_t state_q;
	logic      discard_q;
	logic      fetch_valid_q;

	addr_t  pc_q;
	logic   pred_taken_q;
	addr_t  pred_target_q;
	instr_t instr_q;

	logic accept;
	logic done;

	assign req_ready_o = (state_q == IDLE);
	assign accept      = req_valid_i && req_ready_o;
	assign done        = (state_q == BUSY) && wb_ack_i;

	// Read only; cyc and stb fall with the state after ack.
	assign wb_cyc_o = (state_q == BUSY);
	assign wb_stb_o = (state_q == BUSY);
	assign wb_we_o  = 1'b0;
	assign wb_adr_o = pc_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q       <= IDLE;
			discard_q     <= 1'b0;
			fetch_valid_q <= 1'b0;
		end else begin
			fetch_valid_q <= done && !discard_q && !flush_i;
			case (state_q)
				IDLE: begin
					if (accept) begin
						state_q   <= BUSY;
						discard_q <= flush_i;
					end
				end
				BUSY: begin
					if (flush_i) begin
						discard_q <= 1'b1;
					end
					if (wb_ack_i) begin
						state_q <= IDLE;
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// Request fields stay put until the next accept, past the fetch cycle.
	always_ff @(posedge clk) begin
		if (accept) begin
			pc_q          <= req_pc_i;
			pred_taken_q  <= req_pred_taken_i;
			pred_target_q <= req_pred_target_i;
		end
		if (done) begin
			instr_q <= wb_dat_i;
		end
	end

	assign fetch_o = '{
		valid:       fetch_valid_q,
		pc:          pc_q,
		instr:       instr_q,
		pred_taken:  pred_taken_q,
		pred_target: pred_target_q
	};

endmodule

`default_nettype wire

// File: verilog/pc_sequencer.sv
/*
 * Fetch PC sequencer.
 * Offers the current PC to the bus master, steps it by the BTB answer on
 * acceptance and reloads it from a mispredicted resolve record.
 */

`timescale 1ns/1ns
`default_nettype none

`include "bp_config.svh"

module pc_sequencer (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire bp_pkg::resolve_t resolve_i,
	input  wire                   pred_taken_i,
	input  wire bp_pkg::addr_t    pred_target_i,
	input  wire                   req_ready_i,
	output logic                  req_valid_o,
	output bp_pkg::addr_t         req_pc_o,
	output logic                  req_pred_taken_o,
	output bp_pkg::addr_t         req_pred_target_o,
	output logic                  flush_o
);

	import bp_pkg::*;

	addr_t pc_q;
	logic  flush_q;

	logic  dir_wrong;
	logic  tgt_wrong;
	logic  mispredict;
	addr_t correct_pc;
	addr_t next_pc;
	logic  accept;

	assign dir_wrong  = resolve_i.taken != resolve_i.pred_taken;
	assign tgt_wrong  = resolve_i.taken && (resolve_i.target != resolve_i.pred_target);
	assign mispredict = resolve_i.valid && (dir_wrong || tgt_wrong);

	assign correct_pc = resolve_i.taken ? resolve_i.target : resolve_i.pc + addr_t'(4);

	// Predicted target, or fall through to the next word.
	assign next_pc = pred_taken_i ? pred_target_i : pc_q + addr_t'(4);

	// Hold off requests for the cycle the redirect is being handled.
	assign req_valid_o = !flush_q;
	assign accept      = req_valid_o && req_ready_i;

	assign req_pc_o          = pc_q;
	assign req_pred_taken_o  = pred_taken_i;
	assign req_pred_target_o = pred_target_i;
	assign flush_o           = flush_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_q    <= `BP_RESET_PC;
			flush_q <= 1'b0;
		end else begin
			flush_q <= mispredict;
			// Redirect wins over a same-cycle acceptance.
			if (mispredict) begin
				pc_q <= correct_pc;
			end else if (accept) begin
				pc_q <= next_pc;
			end
		end
	end

endmodule

`default_nettype wire

// File: predictor/btb.sv
/*
 * Direct-mapped branch target buffer.
 * Answers combinationally for the PC on offer and learns from every
 * resolved branch; an update shows in lookups one cycle later.
 */

`timescale 1ns/1ns
`default_nettype none

`include "bp_config.svh"

module btb (
	input  wire              clk,
	input  wire              rst_n,
	input  wire bp_pkg::addr_t    lookup_pc_i,
	output logic             pred_taken_o,
	output bp_pkg::addr_t    pred_target_o,
	input  wire bp_pkg::resolve_t update_i
);

	import bp_pkg::*;

	localparam int unsigned IDX_W = $bits(btb_idx_t);

	logic        valid_q  [`BP_BTB_ENTRIES];
	btb_tag_t    tag_q    [`BP_BTB_ENTRIES];
	addr_t       target_q [`BP_BTB_ENTRIES];
	pred_state_t state_q  [`BP_BTB_ENTRIES];

	btb_idx_t lookup_idx;
	btb_tag_t lookup_tag;
	logic     lookup_hit;

	btb_idx_t upd_idx;
	btb_tag_t upd_tag;
	logic     upd_en;
	logic     upd_hit;

	// One saturating step toward the outcome.
	function automatic pred_state_t step_state(input pred_state_t cur, input logic taken);
		pred_state_t nxt;
		nxt = cur;
		if (taken && (cur != STRONG_T)) begin
			nxt = pred_state_t'(cur + 2'd1);
		end else if (!taken && (cur != STRONG_NT)) begin
			nxt = pred_state_t'(cur - 2'd1);
		end
		return nxt;
	endfunction

	assign lookup_idx = lookup_pc_i[IDX_W+1:2];
	assign lookup_tag = lookup_pc_i[`BP_ADDR_W-1:IDX_W+2];
	assign lookup_hit = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);

	assign pred_taken_o  = lookup_hit && state_q[lookup_idx][1];
	assign pred_target_o = pred_taken_o ? target_q[lookup_idx] : '0;

	assign upd_idx = update_i.pc[IDX_W+1:2];
	assign upd_tag = update_i.pc[`BP_ADDR_W-1:IDX_W+2];
	assign upd_en  = update_i.valid && update_i.is_branch;
	assign upd_hit = valid_q[upd_idx] && (tag_q[upd_idx] == upd_tag);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `BP_BTB_ENTRIES; i++) begin
				valid_q[i] <= 1'b0;
				state_q[i] <= WEAK_NT;
			end
		end else if (upd_en) begin
			if (upd_hit) begin
				state_q[upd_idx] <= step_state(state_q[upd_idx], update_i.taken);
			end else if (update_i.taken) begin
				// Allocate over whatever sat in this slot.
				valid_q[upd_idx] <= 1'b1;
				state_q[upd_idx] <= WEAK_T;
			end
		end
	end

	// A taken outcome writes tag and target on hit and on allocation.
	always_ff @(posedge clk) begin
		if (upd_en && update_i.taken) begin
			tag_q[upd_idx]    <= upd_tag;
			target_q[upd_idx] <= update_i.target;
		end
	end

endmodule

`default_nettype wire

// File: common/bp_pkg.sv
/*
 * Types shared by the fetch front end and its testbench.
 * Holds the address types, the BTB index and tag split, and the
 * fetch and resolve records that travel between fetch and execute.
 */

`default_nettype none

`include "bp_config.svh"

package bp_pkg;

	localparam int unsigned BTB_IDX_W = $clog2(`BP_BTB_ENTRIES);
	// Two low bits select the byte within a word.
	localparam int unsigned BTB_TAG_W = `BP_ADDR_W - BTB_IDX_W - 2;

	typedef logic [`BP_ADDR_W-1:0] addr_t;
	typedef logic [`BP_ADDR_W-1:0] instr_t;
	typedef logic [BTB_IDX_W-1:0] btb_idx_t;
	typedef logic [BTB_TAG_W-1:0] btb_tag_t;

	// Upper half predicts taken.
	typedef enum logic [1:0] {
		STRONG_NT = 2'b00,
		WEAK_NT   = 2'b01,
		WEAK_T    = 2'b10,
		STRONG_T  = 2'b11
	} pred_state_t;

	typedef struct packed {
		logic   valid;
		addr_t  pc;
		instr_t instr;
		logic   pred_taken;
		addr_t  pred_target;
	} fetch_t;

	// Outcome from execute, with the prediction copied from the fetch record.
	typedef struct packed {
		logic  valid;
		logic  is_branch;
		addr_t pc;
		logic  taken;
		addr_t target;
		logic  pred_taken;
		addr_t pred_target;
	} resolve_t;

endpackage

`default_nettype wire

// File: common/bp_config.svh
/*
 * Build-time parameters of the fetch front end.
 * Include wherever address width, BTB depth or reset PC are needed.
 */

`ifndef BP_CONFIG_SVH
`define BP_CONFIG_SVH

// Address and instruction width.
`define BP_ADDR_W 32
// Must be a power of two.
`define BP_BTB_ENTRIES 8
`define BP_RESET_PC 32'h0000_0000

`endif
